// ==== src/mpmc_defines.svh ====
`ifndef MPMC_DEFINES_SVH
`define MPMC_DEFINES_SVH

// ============================================================
// channel side
// ============================================================

// number of requesting channels, the round-robin is built for this count
`define MPMC_NUM_CH 4
`define MPMC_CH_W 2       // width of a channel id

// credits each channel starts with after reset
// this is also the depth of every channel queue, so keep it a power of two
`define MPMC_CREDITS 4

`define MPMC_ADDR_W 32    // channel byte address

// ============================================================
// memory side
// ============================================================

`define MPMC_APP_ADDR_W 29   // native app address width
`define MPMC_DATA_W 128      // one strip of data
`define MPMC_STRB_W 16       // byte lanes in a strip

// the len field holds the strip count minus one, so up to four strips per read
`define MPMC_LEN_W 2

`endif

// ==== src/mpmc_chan_pkg.sv ====
`include "mpmc_defines.svh"

package mpmc_chan_pkg;

	// ============================================================
	// scalar types shared by the channel ports
	// ============================================================

	typedef logic [`MPMC_CH_W-1:0] ch_id_t;          // which channel a request came from
	typedef logic [`MPMC_ADDR_W-1:0] byte_addr_t;    // byte address as the channel sees it
	typedef logic [`MPMC_DATA_W-1:0] strip_data_t;   // one 16-byte strip
	typedef logic [`MPMC_STRB_W-1:0] strb_t;         // one bit per byte lane
	typedef logic [`MPMC_LEN_W-1:0] strip_len_t;     // strip count minus one

	// request presented by a channel, valid for one cycle per credit spent
	typedef struct packed {
		logic        valid;
		logic        we;      // 1 for a single-strip write, 0 for a read
		byte_addr_t  addr;    // low four bits are ignored by the sequencer
		strip_len_t  len;     // only meaningful for reads
		strip_data_t wdata;
		strb_t       wstrb;   // 1 selects the byte lane
	} chan_req_t;

	// read response, shared by all channels and steered by ch
	typedef struct packed {
		logic        valid;
		ch_id_t      ch;
		logic        last;    // final strip of the request
		strip_data_t data;
	} chan_rsp_t;

	// the winning request together with the channel it belongs to
	typedef struct packed {
		chan_req_t req;
		ch_id_t    ch;
	} seq_req_t;

endpackage

// ==== src/mpmc_app_pkg.sv ====
`include "mpmc_defines.svh"

package mpmc_app_pkg;

	// address in the units the memory controller expects
	typedef logic [`MPMC_APP_ADDR_W-1:0] app_addr_t;

	// native command codes, the controller takes three bits
	typedef enum logic [2:0] {
		WRITE = 3'd0,
		READ  = 3'd1
	} app_cmd_e;

	// command channel, held until app_rdy
	typedef struct packed {
		logic      en;
		app_cmd_e  cmd;
		app_addr_t addr;
	} app_cmd_t;

	// write data channel, held until app_wdf_rdy
	typedef struct packed {
		logic                    wren;
		logic                    wend;   // last beat of the write burst
		logic [`MPMC_DATA_W-1:0] data;
		logic [`MPMC_STRB_W-1:0] mask;   // a 1 leaves the byte in memory untouched
	} app_wdf_t;

	// read data coming back, there is no way to stall it
	typedef struct packed {
		logic                    valid;
		logic [`MPMC_DATA_W-1:0] data;
	} app_rd_t;

	// sequencer states
	typedef enum logic [2:0] {
		IDLE,
		WR_DATA,
		WR_CMD,
		RD_CMD,
		RD_WAIT
	} seq_state_e;

endpackage

// ==== src/mpmc_chan_queue.sv ====
`include "mpmc_defines.svh"

module mpmc_chan_queue (
	input  logic                      mem_ui_clk,
	input  logic                      rst,
	input  mpmc_chan_pkg::chan_req_t  req,         // pushed whenever valid is set
	input  logic                      pop,         // grant from the arbiter
	output mpmc_chan_pkg::chan_req_t  head,
	output logic                      not_empty,
	output logic                      credit_ret   // one pulse per popped request
);
	import mpmc_chan_pkg::*;

	localparam int PTR_W = $clog2(`MPMC_CREDITS);

	chan_req_t        slots [`MPMC_CREDITS];   // one slot for every credit the channel holds
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;                   // needs one extra bit to tell full from empty
	logic             push;

	assign push = req.valid;
	assign not_empty = (count != '0);
	assign head = slots[rd_ptr];               // oldest entry is always on the head

	// pointers wrap by themselves since the depth is a power of two
	always_ff @(posedge mem_ui_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_ret <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
			credit_ret <= pop;                 // credit goes back the cycle after the pop
		end
	end

	// storage is payload only
	always_ff @(posedge mem_ui_clk) begin
		if (push)
			slots[wr_ptr] <= req;
	end

	// a push into a full queue means the channel spent a credit it did not have
	a_no_overflow: assert property (@(posedge mem_ui_clk) disable iff (rst)
		push |-> (count != (PTR_W+1)'(`MPMC_CREDITS)))
		else $error("channel pushed a request without holding a credit");

endmodule

// ==== src/mpmc_arbiter.sv ====
`include "mpmc_defines.svh"

module mpmc_arbiter (
	input  logic                       mem_ui_clk,
	input  logic                       rst,
	input  mpmc_chan_pkg::chan_req_t   heads [`MPMC_NUM_CH],   // head of each channel queue
	input  logic [`MPMC_NUM_CH-1:0]    not_empty,
	input  logic                       take,                   // sequencer wants a request now
	output logic [`MPMC_NUM_CH-1:0]    grant,                  // pops the winning queue
	output mpmc_chan_pkg::seq_req_t    winner
);
	import mpmc_chan_pkg::*;

	ch_id_t last_ch;   // channel that won most recently
	ch_id_t pick;
	logic   found;

	// ============================================================
	// search starts at the channel after the last winner
	// ============================================================

	always_comb begin
		ch_id_t cand;
		pick = last_ch;
		found = 1'b0;
		for (int i = 1; i <= `MPMC_NUM_CH; i++) begin
			cand = last_ch + ch_id_t'(i);   // wraps, the last step lands on last_ch again
			if (!found && not_empty[cand]) begin
				pick = cand;
				found = 1'b1;
			end
		end
	end

	always_comb begin
		grant = '0;
		if (take && found)
			grant[pick] = 1'b1;
		winner.req = heads[pick];   // only looked at while take is high
		winner.ch = pick;
	end

	// start out so that channel 0 has the highest priority
	always_ff @(posedge mem_ui_clk) begin
		if (rst) begin
			last_ch <= ch_id_t'(`MPMC_NUM_CH - 1);
		end else if (take && found) begin
			last_ch <= pick;
		end
	end

	// at most one queue pops per cycle, and a take always pops one that holds a request
	a_grant_legal: assert property (@(posedge mem_ui_clk) disable iff (rst)
		$onehot0(grant) && (!take || ((grant & not_empty) != '0)))
		else $error("arbiter grant is not one-hot or a take found no request");

endmodule

// ==== src/mpmc_seq.sv ====
`include "mpmc_defines.svh"

module mpmc_seq (
	input  logic                       mem_ui_clk,
	input  logic                       rst,
	input  logic                       any_pending,   // some channel queue holds a request
	input  mpmc_chan_pkg::seq_req_t    req,           // arbiter winner during take
	output logic                       take,
	input  logic                       app_rdy,
	input  logic                       app_wdf_rdy,
	input  mpmc_app_pkg::app_rd_t      app_rd,
	output mpmc_app_pkg::app_cmd_t     app_cmd,
	output logic                       wdf_wren,
	output logic                       wdf_end,
	output mpmc_chan_pkg::seq_req_t    cur,           // request being worked on
	output mpmc_chan_pkg::chan_rsp_t   rsp
);
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;

	localparam int OFS_W = $clog2(`MPMC_STRB_W);   // byte offset bits inside a strip

	seq_state_e state;
	strip_len_t req_cnt;      // strips whose command has been accepted
	strip_len_t rsp_cnt;      // strips whose data has come back
	byte_addr_t strip_addr;   // byte address of the strip being commanded
	logic       cmd_last;
	logic       rsp_last;

	// only grab a new request when idle, the arbiter answers in the same cycle
	assign take = (state == IDLE) && any_pending;
	assign cmd_last = (req_cnt == cur.req.len);
	assign rsp_last = (rsp_cnt == cur.req.len);

	// align down to a strip and step one strip per accepted command
	assign strip_addr = {cur.req.addr[`MPMC_ADDR_W-1:OFS_W] + req_cnt, OFS_W'(0)};

	// ============================================================
	// state machine and strip counters
	// ============================================================

	always_ff @(posedge mem_ui_clk) begin
		if (rst) begin
			state <= IDLE;
			req_cnt <= '0;
			rsp_cnt <= '0;
		end else begin
			case (state)
			IDLE: begin
				if (take) begin
					state <= req.req.we ? WR_DATA : RD_CMD;
					req_cnt <= '0;
					rsp_cnt <= '0;
				end
			end
			WR_DATA: begin
				if (app_wdf_rdy)
					state <= WR_CMD;   // data goes in first, then the command
			end
			WR_CMD: begin
				if (app_rdy)
					state <= IDLE;     // write is done once the command is taken
			end
			RD_CMD: begin
				if (app_rdy) begin
					if (cmd_last)
						state <= RD_WAIT;
					else
						req_cnt <= req_cnt + 1'b1;
				end
			end
			RD_WAIT: begin
				if (app_rd.valid && rsp_last)
					state <= IDLE;
			end
			default: state <= IDLE;
			endcase
			if (state != IDLE && app_rd.valid)
				rsp_cnt <= rsp_cnt + 1'b1;   // data may start coming back during RD_CMD
		end
	end

	// latched request is payload, it only matters outside IDLE
	always_ff @(posedge mem_ui_clk) begin
		if (take)
			cur <= req;
	end

	// outputs decode straight from registers so they stay put under a stall
	always_comb begin
		app_cmd.en = (state == WR_CMD) || (state == RD_CMD);
		app_cmd.cmd = (state == WR_CMD) ? WRITE : READ;
		app_cmd.addr = strip_addr[`MPMC_APP_ADDR_W-1:0];
	end

	// writes are always a single strip so every data beat is also the last
	assign wdf_wren = (state == WR_DATA);
	assign wdf_end = (state == WR_DATA);

	// tag returned strips with the requester, one cycle behind the memory
	always_ff @(posedge mem_ui_clk) begin
		if (rst)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= app_rd.valid;
		rsp.ch <= cur.ch;
		rsp.last <= rsp_last;
		rsp.data <= app_rd.data;
	end

	// the controller must see the same command until it accepts it
	a_cmd_hold: assert property (@(posedge mem_ui_clk) disable iff (rst)
		app_cmd.en && !app_rdy |=> $stable(app_cmd))
		else $error("app command changed while the controller stalled it");

	// memory must not return data nobody asked for
	a_rd_window: assert property (@(posedge mem_ui_clk) disable iff (rst)
		app_rd.valid |-> (state == RD_CMD) || (state == RD_WAIT))
		else $error("read data arrived outside a read");

endmodule

// ==== src/mpmc_wdata.sv ====
`include "mpmc_defines.svh"

module mpmc_wdata (
	input  logic                        mem_ui_clk,
	input  logic                        rst,
	input  logic                        load,    // capture the winner's write strip
	input  mpmc_chan_pkg::strip_data_t  wdata,
	input  mpmc_chan_pkg::strb_t        wstrb,
	input  logic                        wren,
	input  logic                        wend,
	output mpmc_app_pkg::app_wdf_t      app_wdf
);
	import mpmc_chan_pkg::*;

	strip_data_t forced;   // write data with unselected lanes set to FF
	strip_data_t data_q;
	strb_t       mask_q;

	// ============================================================
	// lane forcing
	// ============================================================

	for (genvar g = 0; g < `MPMC_STRB_W; g++) begin : g_lane
		assign forced[g*8 +: 8] = wstrb[g] ? wdata[g*8 +: 8] : 8'hFF;
	end

	// mask comes out of reset with every lane blocked
	always_ff @(posedge mem_ui_clk) begin
		if (rst)
			mask_q <= '1;
		else if (load)
			mask_q <= ~wstrb;   // controller masks where the channel did not select
	end

	always_ff @(posedge mem_ui_clk) begin
		if (load)
			data_q <= forced;
	end

	assign app_wdf = '{wren: wren, wend: wend, data: data_q, mask: mask_q};

endmodule

// ==== src/mpmc_top.sv ====
`include "mpmc_defines.svh"

module mpmc_top (
	input  logic                       mem_ui_clk,
	input  logic                       rst,
	input  mpmc_chan_pkg::chan_req_t   ch_req [`MPMC_NUM_CH],
	output logic [`MPMC_NUM_CH-1:0]    credit_ret,
	output mpmc_chan_pkg::chan_rsp_t   rsp,
	output mpmc_app_pkg::app_cmd_t     app_cmd,
	input  logic                       app_rdy,
	output mpmc_app_pkg::app_wdf_t     app_wdf,
	input  logic                       app_wdf_rdy,
	input  mpmc_app_pkg::app_rd_t      app_rd
);
	import mpmc_chan_pkg::*;

	chan_req_t                heads [`MPMC_NUM_CH];
	logic [`MPMC_NUM_CH-1:0]  not_empty;
	logic [`MPMC_NUM_CH-1:0]  grant;
	seq_req_t                 winner;
	logic                     take;
	logic                     wdf_wren;
	logic                     wdf_end;

	// ============================================================
	// one queue per channel, each pops on its own grant bit
	// ============================================================

	for (genvar c = 0; c < `MPMC_NUM_CH; c++) begin : g_ch
		mpmc_chan_queue queue_i (
			.mem_ui_clk (mem_ui_clk),
			.rst        (rst),
			.req        (ch_req[c]),
			.pop        (grant[c]),
			.head       (heads[c]),
			.not_empty  (not_empty[c]),
			.credit_ret (credit_ret[c])
		);
	end

	mpmc_arbiter arb_i (
		.mem_ui_clk (mem_ui_clk),
		.rst        (rst),
		.heads      (heads),
		.not_empty  (not_empty),
		.take       (take),
		.grant      (grant),
		.winner     (winner)
	);

	mpmc_seq seq_i (
		.mem_ui_clk  (mem_ui_clk),
		.rst         (rst),
		.any_pending (|not_empty),
		.req         (winner),
		.take        (take),
		.app_rdy     (app_rdy),
		.app_wdf_rdy (app_wdf_rdy),
		.app_rd      (app_rd),
		.app_cmd     (app_cmd),
		.wdf_wren    (wdf_wren),
		.wdf_end     (wdf_end),
		.cur         (),            // only needed inside the sequencer
		.rsp         (rsp)
	);

	// write strip is captured at take, one cycle before WR_DATA drives it
	mpmc_wdata wdata_i (
		.mem_ui_clk (mem_ui_clk),
		.rst        (rst),
		.load       (take),
		.wdata      (winner.req.wdata),
		.wstrb      (winner.req.wstrb),
		.wren       (wdf_wren),
		.wend       (wdf_end),
		.app_wdf    (app_wdf)
	);

endmodule

// ==== dv/mpmc_app_model.sv ====
`include "mpmc_defines.svh"

module mpmc_app_model (
	input  logic                    mem_ui_clk,
	input  logic                    rst,
	input  logic                    hold_cmd,   // forces app_rdy low while set
	input  mpmc_app_pkg::app_cmd_t  app_cmd,
	output logic                    app_rdy,
	input  mpmc_app_pkg::app_wdf_t  app_wdf,
	output logic                    app_wdf_rdy,
	output mpmc_app_pkg::app_rd_t   app_rd
);
	import mpmc_app_pkg::*;

	localparam int RD_LAT = 4;   // shortest gap from an accepted read to its data

	logic [`MPMC_DATA_W-1:0] mem [app_addr_t];   // sparse, unwritten strips read as zero
	logic [`MPMC_DATA_W-1:0] wdf_q [$];          // data beats waiting for their command
	logic [`MPMC_STRB_W-1:0] mask_q [$];
	logic [`MPMC_DATA_W-1:0] rd_q [$];           // read strips in flight, in command order
	int                      due_q [$];          // cycle at which each one may come back
	int                      cyc;

	initial begin : model
		logic [`MPMC_DATA_W-1:0] line;
		logic [`MPMC_DATA_W-1:0] wd;
		logic [`MPMC_STRB_W-1:0] wm;
		void'($urandom(89217));   // one seed drives every stall and latency choice
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd = '0;
		cyc = 0;
		forever begin
			@(posedge mem_ui_clk);
			if (rst) begin
				app_rdy <= 1'b0;
				app_wdf_rdy <= 1'b0;
				app_rd <= '0;
				cyc = 0;
				wdf_q.delete();
				mask_q.delete();
				rd_q.delete();
				due_q.delete();
			end else begin
				cyc = cyc + 1;
				if (app_wdf.wren && app_wdf_rdy) begin
					wdf_q.push_back(app_wdf.data);   // a write beat always comes before its command
					mask_q.push_back(app_wdf.mask);
				end
				if (app_cmd.en && app_rdy) begin
					line = mem.exists(app_cmd.addr) ? mem[app_cmd.addr] : '0;
					if (app_cmd.cmd == WRITE) begin
						wd = wdf_q.pop_front();
						wm = mask_q.pop_front();
						for (int b = 0; b < `MPMC_STRB_W; b++)
							if (!wm[b])
								line[b*8 +: 8] = wd[b*8 +: 8];   // mask bit 1 keeps the old byte
						mem[app_cmd.addr] = line;
					end else begin
						rd_q.push_back(line);
						due_q.push_back(cyc + RD_LAT + int'($urandom % 4));
					end
				end
				// strips leave in order even when a later one is already due
				if (due_q.size() != 0 && due_q[0] <= cyc) begin
					app_rd.valid <= 1'b1;
					app_rd.data <= rd_q.pop_front();
					void'(due_q.pop_front());
				end else begin
					app_rd.valid <= 1'b0;
				end
				app_rdy <= !hold_cmd && ($urandom % 4 != 0);   // ready about three cycles in four
				app_wdf_rdy <= ($urandom % 4 != 0);
			end
		end
	end

endmodule

// ==== dv/tb_mpmc.sv ====
`include "mpmc_defines.svh"

module tb_mpmc;
	import mpmc_chan_pkg::*;
	import mpmc_app_pkg::*;

	// about two dozen requests, each done in well under a hundred cycles even with stalls
	localparam int MAX_CYCLES = 20000;

	logic                    mem_ui_clk;
	logic                    rst;
	logic                    hold_cmd;
	chan_req_t               ch_req [`MPMC_NUM_CH];
	logic [`MPMC_NUM_CH-1:0] credit_ret;
	chan_rsp_t               rsp;
	app_cmd_t                app_cmd;
	logic                    app_rdy;
	app_wdf_t                app_wdf;
	logic                    app_wdf_rdy;
	app_rd_t                 app_rd;

	int          cycles;
	int          checks;
	int          errors;
	int          sent [`MPMC_NUM_CH];       // requests each channel has issued
	int          ret_seen [`MPMC_NUM_CH];   // credit pulses each channel has received
	chan_rsp_t   rsp_q [$];
	strip_data_t ref_mem [byte_addr_t];     // expected memory, keyed by strip-aligned address
	ch_id_t      last_win;                  // channel the arbiter served most recently

	mpmc_top dut_i (
		.mem_ui_clk (mem_ui_clk), .rst (rst), .ch_req (ch_req), .credit_ret (credit_ret),
		.rsp (rsp), .app_cmd (app_cmd), .app_rdy (app_rdy), .app_wdf (app_wdf),
		.app_wdf_rdy (app_wdf_rdy), .app_rd (app_rd)
	);

	mpmc_app_model model_i (
		.mem_ui_clk (mem_ui_clk), .rst (rst), .hold_cmd (hold_cmd), .app_cmd (app_cmd),
		.app_rdy (app_rdy), .app_wdf (app_wdf), .app_wdf_rdy (app_wdf_rdy), .app_rd (app_rd)
	);

	always #2 mem_ui_clk = ~mem_ui_clk;

	always @(posedge mem_ui_clk) begin
		if (!rst) begin
			for (int c = 0; c < `MPMC_NUM_CH; c++)
				ret_seen[c] += int'(credit_ret[c]);
			if (rsp.valid)
				rsp_q.push_back(rsp);   // the response bus has no back-pressure
			if (app_wdf.wren)
				check("app_wdf.wend", app_wdf.wend, 1'b1);   // every write is a single strip
		end
	end

	always @(posedge mem_ui_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ============================================================
	// helpers
	// ============================================================

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	function automatic byte_addr_t chan_addr(input int ch);
		return 32'h1000 * (ch + 1);   // each channel owns one strip
	endfunction

	function automatic strip_data_t pattern(input int ch, input byte_addr_t a);
		return {a, ~a, a ^ 32'hDEAD_BEEF, 32'h5A00_0000 | ch};
	endfunction

	function automatic strip_data_t ref_data(input byte_addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : '0;
	endfunction

	// requests are driven from a clock edge and valid drops one edge later
	task automatic send(input int ch, input logic we, input byte_addr_t addr,
			input strip_len_t len, input strip_data_t data, input strb_t strb);
		while (`MPMC_CREDITS - sent[ch] + ret_seen[ch] == 0)
			@(posedge mem_ui_clk);   // out of credits, wait for a pulse
		ch_req[ch] <= '{valid: 1'b1, we: we, addr: addr, len: len, wdata: data, wstrb: strb};
		sent[ch]++;
		@(posedge mem_ui_clk);
		ch_req[ch].valid <= 1'b0;
	endtask

	task automatic write_strip(input int ch, input byte_addr_t addr, input strip_data_t data,
			input strb_t strb);
		strip_data_t line;
		line = ref_data(addr & ~32'hF);
		for (int b = 0; b < `MPMC_STRB_W; b++)
			if (strb[b])
				line[b*8 +: 8] = data[b*8 +: 8];   // unselected lanes keep what memory held
		ref_mem[addr & ~32'hF] = line;
		send(ch, 1'b1, addr, '0, data, strb);
		last_win = ch_id_t'(ch);
	endtask

	task automatic wait_rsp(input int n);
		while (rsp_q.size() < n)
			@(posedge mem_ui_clk);
	endtask

	task automatic read_check(input int ch, input byte_addr_t addr, input int len);
		chan_rsp_t r;
		send(ch, 1'b0, addr, strip_len_t'(len), '0, '0);
		last_win = ch_id_t'(ch);
		wait_rsp(len + 1);
		for (int k = 0; k <= len; k++) begin
			r = rsp_q.pop_front();
			check("rsp.ch", r.ch, ch);
			check("rsp.last", r.last, k == len);
			check("rsp.data", r.data, ref_data((addr & ~32'hF) + 16 * k));
		end
	endtask

	// ============================================================
	// tests
	// ============================================================

	task automatic test_reset_values();
		check("app_cmd.en", app_cmd.en, 0);
		check("app_wdf.wren", app_wdf.wren, 0);
		check("rsp.valid", rsp.valid, 0);
		check("credit_ret", credit_ret, 0);
	endtask

	task automatic test_write_read_each();
		for (int c = 0; c < `MPMC_NUM_CH; c++) begin
			write_strip(c, chan_addr(c), pattern(c, chan_addr(c)), '1);
			read_check(c, chan_addr(c), 0);
		end
	endtask

	task automatic test_four_strip_read();
		for (int k = 0; k < 4; k++)
			write_strip(1, 32'h8000 + 16 * k, pattern(1, 32'h8000 + 16 * k), '1);
		read_check(1, 32'h8000, 3);
	endtask

	task automatic test_partial_strobe();
		write_strip(2, chan_addr(2), {4{32'h0102_0304}}, 16'h0F0F);
		read_check(2, chan_addr(2), 0);
	endtask

	task automatic test_all_channels();
		chan_rsp_t r;
		ch_id_t    exp_ch;
		for (int c = 0; c < `MPMC_NUM_CH; c++) begin
			ch_req[c] <= '{valid: 1'b1, we: 1'b0, addr: chan_addr(c), len: '0,
				wdata: '0, wstrb: '0};
			sent[c]++;
		end
		@(posedge mem_ui_clk);
		for (int c = 0; c < `MPMC_NUM_CH; c++)
			ch_req[c].valid <= 1'b0;
		wait_rsp(`MPMC_NUM_CH);
		for (int i = 0; i < `MPMC_NUM_CH; i++) begin
			exp_ch = last_win + ch_id_t'(i + 1);   // rotation starts after the last winner
			r = rsp_q.pop_front();
			check("rsp.ch", r.ch, exp_ch);
			check("rsp.data", r.data, ref_data(chan_addr(exp_ch)));
		end
		last_win = exp_ch;
	endtask

	task automatic test_credit_stall();
		chan_rsp_t r;
		int        base;
		base = ret_seen[3];
		hold_cmd <= 1'b1;
		for (int k = 0; k < `MPMC_CREDITS; k++)
			send(3, 1'b0, 32'h8000 + 16 * k, '0, '0, '0);   // back-to-back, one per cycle
		repeat (20) @(posedge mem_ui_clk);
		// only the request taken into the sequencer has returned its credit
		check("credit_ret pulses while stalled", ret_seen[3] - base, 1);
		hold_cmd <= 1'b0;
		wait_rsp(`MPMC_CREDITS);
		for (int k = 0; k < `MPMC_CREDITS; k++) begin
			r = rsp_q.pop_front();
			check("rsp.ch", r.ch, 3);
			check("rsp.data", r.data, ref_data(32'h8000 + 16 * k));
		end
		check("credit_ret pulses", ret_seen[3] - base, `MPMC_CREDITS);
		last_win = 3;
	endtask

	initial begin
		mem_ui_clk = 1'b0;
		rst = 1'b1;
		hold_cmd = 1'b0;
		cycles = 0;
		checks = 0;
		errors = 0;
		for (int c = 0; c < `MPMC_NUM_CH; c++) begin
			ch_req[c] = '0;
			sent[c] = 0;
			ret_seen[c] = 0;
		end
		repeat (4) @(posedge mem_ui_clk);
		rst <= 1'b0;
		@(posedge mem_ui_clk);
		test_reset_values();
		test_write_read_each();
		test_four_strip_read();
		test_partial_strobe();
		test_all_channels();
		test_credit_stall();
		repeat (5) @(posedge mem_ui_clk);
		$display("checks %0d, errors %0d, responses left over %0d", checks, errors, rsp_q.size());
		if (errors == 0 && rsp_q.size() == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== mpmc_lite.f ====
+incdir+src
src/mpmc_chan_pkg.sv
src/mpmc_app_pkg.sv
src/mpmc_chan_queue.sv
src/mpmc_arbiter.sv
src/mpmc_seq.sv
src/mpmc_wdata.sv
src/mpmc_top.sv
dv/mpmc_app_model.sv
dv/tb_mpmc.sv

// ==== Bender.yml ====
package:
  name: mpmc_lite

sources:
  - include_dirs:
      - src
    files:
      - src/mpmc_chan_pkg.sv
      - src/mpmc_app_pkg.sv
      - src/mpmc_chan_queue.sv
      - src/mpmc_arbiter.sv
      - src/mpmc_seq.sv
      - src/mpmc_wdata.sv
      - src/mpmc_top.sv
      - target: test
        files:
          - dv/mpmc_app_model.sv
          - dv/tb_mpmc.sv
